//--- common/eth_video_defines.svh
`ifndef ETH_VIDEO_DEFINES_SVH
`define ETH_VIDEO_DEFINES_SVH

// ethertype carried by FFCP frames
`define ETHERTYPE_FFCP 16'h88B5

// FFCP type byte values
`define FFCP_TYPE_SYN 8'd0
`define FFCP_TYPE_ACK 8'd1
`define FFCP_TYPE_MSG 8'd2

// one offset byte followed by 12 data bytes
`define FGP_LEN 13
`define FGP_SLOT_BITS 4
`define FFCP_BUFFER_LEN 8
`define FGP_COLORS 8

`define VRAM_ADDR_BITS 8
`define COLOR_LEN 12

// destination and source MAC addresses
`define MAC_HDR_LEN 12

`endif

//--- common/eth_video_pkg.sv
`default_nettype none

`include "eth_video_defines.svh"

package eth_video_pkg;

	localparam int SLOT_IDX_BITS = $clog2(`FFCP_BUFFER_LEN);
	localparam int BUF_ADDR_BITS = SLOT_IDX_BITS + `FGP_SLOT_BITS;

	typedef struct packed {
		logic crsdv;
		logic [1:0] rxd;
		logic rxerr;
	} rmii_t;

	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} byte_stb_t;

	typedef struct packed {
		logic done;
		logic err;
	} frame_end_t;

	typedef struct packed {
		logic we;
		logic [BUF_ADDR_BITS-1:0] addr;
		logic [7:0] data;
	} buf_wr_t;

	typedef struct packed {
		logic re;
		logic [BUF_ADDR_BITS-1:0] addr;
	} buf_rd_t;

	typedef struct packed {
		logic valid;
		logic [SLOT_IDX_BITS-1:0] slot;
	} commit_t;

	typedef struct packed {
		logic we;
		logic [`VRAM_ADDR_BITS-1:0] addr;
		logic [`COLOR_LEN-1:0] color;
	} vram_wr_t;

endpackage

`default_nettype wire

//--- source/rmii_rx.sv
`timescale 1ns/1ns
`default_nettype none

module rmii_rx import eth_video_pkg::*; (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input rmii_t rmii,
	output byte_stb_t rx_byte,
	output frame_end_t rx_end
);

	logic in_frame;
	logic err_hold;
	logic pre_seen;
	logic [1:0] dibit_cnt;
	logic [7:0] shreg;
	logic byte_vld;
	logic end_done;
	logic end_err;
	logic shift_en;

	// a dibit of frame data is only taken on a clean sample
	assign shift_en = in_frame && rmii.crsdv && !rmii.rxerr;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			in_frame <= 1'b0;
			err_hold <= 1'b0;
			pre_seen <= 1'b0;
			dibit_cnt <= 2'd0;
			byte_vld <= 1'b0;
			end_done <= 1'b0;
			end_err <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			end_done <= 1'b0;
			end_err <= 1'b0;
			if (err_hold) begin
				// drop the rest of a broken frame until the carrier goes away
				if (!rmii.crsdv)
					err_hold <= 1'b0;
			end else if (rmii.crsdv && rmii.rxerr) begin
				err_hold <= 1'b1;
				in_frame <= 1'b0;
				pre_seen <= 1'b0;
				end_err <= 1'b1;
			end else if (!rmii.crsdv) begin
				end_done <= in_frame;
				in_frame <= 1'b0;
				pre_seen <= 1'b0;
			end else if (in_frame) begin
				dibit_cnt <= dibit_cnt + 2'd1;
				if (dibit_cnt == 2'd3)
					byte_vld <= 1'b1;
			end else if (pre_seen && rmii.rxd == 2'b11) begin
				// SFD closes the preamble
				in_frame <= 1'b1;
				dibit_cnt <= 2'd0;
			end else begin
				pre_seen <= rmii.rxd == 2'b01;
			end
		end
	end

	// dibits arrive LSB first, so shift in from the top
	always_ff @(posedge clk) begin
		if (shift_en)
			shreg <= {rmii.rxd, shreg[7:2]};
	end

	assign rx_byte = '{valid: byte_vld, data: shreg};
	assign rx_end = '{done: end_done, err: end_err};

endmodule

`default_nettype wire

//--- frame/eth_frame_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_video_defines.svh"

module eth_frame_rx import eth_video_pkg::*; (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input byte_stb_t rx_byte,
	input frame_end_t rx_end,
	output byte_stb_t ffcp_byte,
	output frame_end_t ffcp_end
);

	// MAC addresses plus the two ethertype bytes
	localparam int HDR_LEN = `MAC_HDR_LEN + 2;
	localparam int CNT_BITS = $clog2(HDR_LEN + 1);

	logic [CNT_BITS-1:0] hdr_cnt;
	logic [7:0] etype_hi;
	logic ffcp_en;
	logic fwd_vld;
	logic [7:0] fwd_data;
	logic end_done;
	logic end_err;
	logic frame_over;

	assign frame_over = rx_end.done || rx_end.err;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			hdr_cnt <= '0;
			ffcp_en <= 1'b0;
			fwd_vld <= 1'b0;
			end_done <= 1'b0;
			end_err <= 1'b0;
		end else begin
			fwd_vld <= 1'b0;
			end_done <= rx_end.done && ffcp_en;
			end_err <= rx_end.err && ffcp_en;
			if (frame_over) begin
				hdr_cnt <= '0;
				ffcp_en <= 1'b0;
			end else if (rx_byte.valid) begin
				if (hdr_cnt != CNT_BITS'(HDR_LEN))
					hdr_cnt <= hdr_cnt + 1'b1;
				if (hdr_cnt == CNT_BITS'(HDR_LEN - 1))
					ffcp_en <= {etype_hi, rx_byte.data} == `ETHERTYPE_FFCP;
				// payload bytes only once the ethertype matched
				fwd_vld <= ffcp_en && hdr_cnt == CNT_BITS'(HDR_LEN);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_byte.valid) begin
			fwd_data <= rx_byte.data;
			if (hdr_cnt == CNT_BITS'(`MAC_HDR_LEN))
				etype_hi <= rx_byte.data;
		end
	end

	assign ffcp_byte = '{valid: fwd_vld, data: fwd_data};
	assign ffcp_end = '{done: end_done, err: end_err};

endmodule

`default_nettype wire

//--- frame/ffcp_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_video_defines.svh"

module ffcp_rx import eth_video_pkg::*; (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input byte_stb_t ffcp_byte,
	input frame_end_t ffcp_end,
	output buf_wr_t buf_wr,
	output commit_t commit
);

	// type, index, then the datagram
	localparam int PAY_END = `FGP_LEN + 2;
	localparam int CNT_BITS = $clog2(PAY_END + 1);

	logic [CNT_BITS-1:0] byte_cnt;
	logic [7:0] type_q;
	logic [SLOT_IDX_BITS-1:0] idx_q;
	logic wr_en;
	logic [BUF_ADDR_BITS-1:0] wr_addr;
	logic [7:0] wr_data;
	logic commit_vld;
	logic payload_byte;
	logic [CNT_BITS-1:0] wr_cnt;

	assign payload_byte = ffcp_byte.valid && byte_cnt >= CNT_BITS'(2) &&
		byte_cnt < CNT_BITS'(PAY_END);

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			byte_cnt <= '0;
			wr_en <= 1'b0;
			commit_vld <= 1'b0;
			wr_cnt <= '0;
		end else begin
			wr_en <= payload_byte;
			commit_vld <= 1'b0;
			if (ffcp_end.err) begin
				byte_cnt <= '0;
			end else if (ffcp_end.done) begin
				// only a full MSG datagram is handed on
				commit_vld <= type_q == `FFCP_TYPE_MSG &&
					byte_cnt == CNT_BITS'(PAY_END);
				byte_cnt <= '0;
			end else if (ffcp_byte.valid && byte_cnt != CNT_BITS'(PAY_END)) begin
				byte_cnt <= byte_cnt + 1'b1;
			end
			// buffer writes seen since the last frame end
			if (ffcp_end.done || ffcp_end.err)
				wr_cnt <= '0;
			else if (wr_en)
				wr_cnt <= wr_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ffcp_byte.valid && byte_cnt == CNT_BITS'(0))
			type_q <= ffcp_byte.data;
		if (ffcp_byte.valid && byte_cnt == CNT_BITS'(1))
			idx_q <= ffcp_byte.data[SLOT_IDX_BITS-1:0];
		if (payload_byte) begin
			wr_addr <= {idx_q, `FGP_SLOT_BITS'(byte_cnt - CNT_BITS'(2))};
			wr_data <= ffcp_byte.data;
		end
	end

	assign buf_wr = '{we: wr_en, addr: wr_addr, data: wr_data};
	assign commit = '{valid: commit_vld, slot: idx_q};

	// a frame never writes more than one datagram into the buffer
	a_wr_per_frame: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		buf_wr.we |-> wr_cnt < CNT_BITS'(`FGP_LEN));

endmodule

`default_nettype wire

//--- source/packet_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_video_defines.svh"

module packet_buffer #(
	parameter int ADDR_BITS = $clog2(`FFCP_BUFFER_LEN) + `FGP_SLOT_BITS
) (
	input wire logic clk,
	input wire logic [ADDR_BITS+8:0] buf_wr,
	input wire logic [ADDR_BITS:0] buf_rd,
	output logic [7:0] rd_data
);

	localparam int DEPTH = 2 ** ADDR_BITS;

	logic [7:0] mem [DEPTH];

	// write port is {we, addr, data}, read port is {re, addr}
	always_ff @(posedge clk) begin
		if (buf_wr[ADDR_BITS+8])
			mem[buf_wr[ADDR_BITS+7:8]] <= buf_wr[7:0];
		if (buf_rd[ADDR_BITS])
			rd_data <= mem[buf_rd[ADDR_BITS-1:0]];
	end

endmodule

`default_nettype wire

//--- playback/slot_streamer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_video_defines.svh"

module slot_streamer import eth_video_pkg::*; (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input commit_t commit,
	output buf_rd_t buf_rd,
	input wire logic [7:0] rd_data,
	output byte_stb_t dgram_byte,
	output logic dgram_start
);

	logic busy;
	logic [SLOT_IDX_BITS-1:0] slot_q;
	logic [`FGP_SLOT_BITS-1:0] rd_pos;
	logic rd_vld;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			busy <= 1'b0;
			rd_pos <= '0;
			rd_vld <= 1'b0;
			dgram_start <= 1'b0;
		end else begin
			// one stage to match the buffer read latency
			rd_vld <= busy;
			dgram_start <= busy && rd_pos == '0;
			if (commit.valid) begin
				busy <= 1'b1;
				rd_pos <= '0;
			end else if (busy) begin
				rd_pos <= rd_pos + 1'b1;
				if (rd_pos == `FGP_SLOT_BITS'(`FGP_LEN - 1))
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (commit.valid)
			slot_q <= commit.slot;
	end

	assign buf_rd = '{re: busy, addr: {slot_q, rd_pos}};
	assign dgram_byte = '{valid: rd_vld, data: rd_data};

	// the receiver must not commit again before this slot is fully read
	a_no_commit_busy: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		commit.valid |-> !busy);

endmodule

`default_nettype wire

//--- playback/fgp_to_vram.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_video_defines.svh"

module fgp_to_vram import eth_video_pkg::*; (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input wire logic dgram_start,
	input byte_stb_t dgram_byte,
	output vram_wr_t vram_wr
);

	localparam int COL_SHIFT = $clog2(`FGP_COLORS);
	localparam int OFS_BITS = `VRAM_ADDR_BITS - COL_SHIFT;
	localparam int CNT_BITS = $clog2(`FGP_COLORS + 1);

	logic active;
	logic [1:0] phase;
	logic [CNT_BITS-1:0] col_cnt;
	logic [`VRAM_ADDR_BITS-1:0] next_addr;
	logic [7:0] hold_b;
	logic [3:0] hold_nib;
	logic wr_en;
	logic [`VRAM_ADDR_BITS-1:0] wr_addr;
	logic [`COLOR_LEN-1:0] wr_color;
	logic color_out;

	// phases 1 and 2 each finish a color
	assign color_out = active && dgram_byte.valid && !dgram_start && phase != 2'd0;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			active <= 1'b0;
			phase <= 2'd0;
			col_cnt <= '0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= color_out;
			if (dgram_start && dgram_byte.valid) begin
				active <= 1'b1;
				phase <= 2'd0;
				col_cnt <= '0;
			end else if (active && dgram_byte.valid) begin
				phase <= phase == 2'd2 ? 2'd0 : phase + 2'd1;
				if (color_out) begin
					col_cnt <= col_cnt + 1'b1;
					// last color ends the datagram
					if (col_cnt == CNT_BITS'(`FGP_COLORS - 1))
						active <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dgram_start && dgram_byte.valid) begin
			// offset counts in whole datagrams of colors
			next_addr <= {dgram_byte.data[OFS_BITS-1:0], {COL_SHIFT{1'b0}}};
		end else if (color_out) begin
			next_addr <= next_addr + 1'b1;
			wr_addr <= next_addr;
		end
		if (dgram_byte.valid && phase == 2'd0)
			hold_b <= dgram_byte.data;
		if (color_out && phase == 2'd1) begin
			wr_color <= {hold_b, dgram_byte.data[7:4]};
			hold_nib <= dgram_byte.data[3:0];
		end else if (color_out) begin
			wr_color <= {hold_nib, dgram_byte.data};
		end
	end

	assign vram_wr = '{we: wr_en, addr: wr_addr, color: wr_color};

	a_colors_per_dgram: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		vram_wr.we |-> col_cnt != '0 && col_cnt <= CNT_BITS'(`FGP_COLORS));

endmodule

`default_nettype wire

//--- source/eth_video_rx.sv
`timescale 1ns/1ns
`default_nettype none

module eth_video_rx import eth_video_pkg::*; (
	input wire logic clk,
	input wire logic eth_rx_downstream_rst,
	input rmii_t rmii,
	output vram_wr_t vram_wr,
	output logic frame_err
);

	byte_stb_t rx_byte;
	frame_end_t rx_end;
	byte_stb_t ffcp_byte;
	frame_end_t ffcp_end;
	buf_wr_t buf_wr;
	buf_rd_t buf_rd;
	commit_t commit;
	logic [7:0] rd_data;
	byte_stb_t dgram_byte;
	logic dgram_start;

	rmii_rx rmii_rx_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rmii(rmii),
		.rx_byte(rx_byte),
		.rx_end(rx_end)
	);

	eth_frame_rx eth_frame_rx_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rx_byte(rx_byte),
		.rx_end(rx_end),
		.ffcp_byte(ffcp_byte),
		.ffcp_end(ffcp_end)
	);

	ffcp_rx ffcp_rx_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.ffcp_byte(ffcp_byte),
		.ffcp_end(ffcp_end),
		.buf_wr(buf_wr),
		.commit(commit)
	);

	packet_buffer #(.ADDR_BITS(BUF_ADDR_BITS)) packet_buffer_i (
		.clk(clk),
		.buf_wr(buf_wr),
		.buf_rd(buf_rd),
		.rd_data(rd_data)
	);

	slot_streamer slot_streamer_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.commit(commit),
		.buf_rd(buf_rd),
		.rd_data(rd_data),
		.dgram_byte(dgram_byte),
		.dgram_start(dgram_start)
	);

	fgp_to_vram fgp_to_vram_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.dgram_start(dgram_start),
		.dgram_byte(dgram_byte),
		.vram_wr(vram_wr)
	);

	// errors are only reported for FFCP frames
	assign frame_err = ffcp_end.err;

endmodule

`default_nettype wire

//--- testbench/tb_frame_tasks.svh
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

// linear congruential generator for the datagram bytes
function automatic logic [31:0] next_random();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

task automatic check_value(input string what, input logic [31:0] got,
	input logic [31:0] exp);
	check_count++;
	if (got !== exp) begin
		$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		error_count++;
	end
endtask

// one RMII sample, changed shortly after the rising edge
task automatic drive_sample(input logic crsdv, input logic [1:0] rxd, input logic rxerr);
	@(posedge clk);
	#1;
	rmii = '{crsdv: crsdv, rxd: rxd, rxerr: rxerr};
endtask

task automatic idle_cycles(input int n);
	repeat (n) drive_sample(1'b0, 2'b00, 1'b0);
endtask

// fills frame_bytes, keeps the datagram in dgram_bytes
task automatic build_frame(input logic [15:0] etype, input logic [7:0] ftype,
	input logic [7:0] index, input logic [7:0] offset, input int dgram_len);
	logic [31:0] rnd;
	frame_bytes.delete();
	for (int i = 0; i < `MAC_HDR_LEN; i++)
		frame_bytes.push_back(8'h10 + 8'(i));
	frame_bytes.push_back(etype[15:8]);
	frame_bytes.push_back(etype[7:0]);
	frame_bytes.push_back(ftype);
	frame_bytes.push_back(index);
	dgram_bytes[0] = offset;
	for (int i = 1; i < dgram_len; i++) begin
		rnd = next_random();
		dgram_bytes[i] = rnd[31:24];
	end
	for (int i = 0; i < dgram_len; i++)
		frame_bytes.push_back(dgram_bytes[i]);
endtask

// preamble and SFD, then each byte as four dibits LSB first;
// rxerr goes high on the first dibit of byte err_at
task automatic send_frame(input int err_at);
	logic [7:0] b;
	for (int i = 0; i < PREAMBLE_DIBITS - 1; i++)
		drive_sample(1'b1, 2'b01, 1'b0);
	drive_sample(1'b1, 2'b11, 1'b0);
	for (int i = 0; i < frame_bytes.size(); i++) begin
		b = frame_bytes[i];
		for (int d = 0; d < 4; d++)
			drive_sample(1'b1, b[2*d +: 2], i == err_at && d == 0);
	end
	idle_cycles(IFG_CYCLES);
endtask

// three data bytes give two colors, placed from offset times FGP_COLORS
task automatic expect_dgram();
	logic [7:0] base;
	logic [7:0] b0;
	logic [7:0] b1;
	logic [7:0] b2;
	base = 8'(dgram_bytes[0][4:0] * `FGP_COLORS);
	for (int k = 0; k < (`FGP_LEN - 1) / 3; k++) begin
		b0 = dgram_bytes[1 + 3 * k];
		b1 = dgram_bytes[2 + 3 * k];
		b2 = dgram_bytes[3 + 3 * k];
		exp_vram[base + 8'(2 * k)] = {b0, b1[7:4]};
		exp_vram[base + 8'(2 * k + 1)] = {b1[3:0], b2};
	end
	exp_writes += `FGP_COLORS;
endtask

`endif

//--- testbench/tb_eth_video_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_video_defines.svh"

module tb_eth_video_rx import eth_video_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int RST_CYCLES = 10;
	localparam int IDLE_CYCLES = 40;
	localparam int IFG_CYCLES = 12;
	localparam int PREAMBLE_DIBITS = 32;
	// MAC header, ethertype, type, index and a full datagram
	localparam int MAX_FRAME_BYTES = `MAC_HDR_LEN + 4 + `FGP_LEN;
	localparam int FRAME_CYCLES = PREAMBLE_DIBITS + 4 * MAX_FRAME_BYTES + IFG_CYCLES;
	localparam int NUM_FRAMES = 11;
	localparam int NUM_IDLES = 6;
	localparam int TIMEOUT_NS = 2 * CLK_PERIOD *
		(NUM_FRAMES * FRAME_CYCLES + NUM_IDLES * IDLE_CYCLES + RST_CYCLES);

	logic clk = 1'b0;
	logic eth_rx_downstream_rst;
	rmii_t rmii;
	vram_wr_t vram_wr;
	logic frame_err;

	logic [`COLOR_LEN-1:0] vram [256];
	logic [`COLOR_LEN-1:0] exp_vram [256];
	int vram_writes;
	int err_pulses;
	int exp_writes;
	int exp_err_pulses;
	int error_count;
	int check_count;
	int tests_run;
	int tests_failed;
	logic [31:0] lcg_state;
	logic [7:0] frame_bytes [$];
	logic [7:0] dgram_bytes [`FGP_LEN];

	`include "tb_frame_tasks.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	eth_video_rx eth_video_rx_i (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rmii(rmii),
		.vram_wr(vram_wr),
		.frame_err(frame_err)
	);

	// VRAM model, also counts writes and error pulses
	always @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			for (int a = 0; a < 256; a++)
				vram[a] <= '0;
			vram_writes <= 0;
			err_pulses <= 0;
		end else begin
			if (vram_wr.we) begin
				vram[vram_wr.addr] <= vram_wr.color;
				vram_writes <= vram_writes + 1;
			end
			if (frame_err)
				err_pulses <= err_pulses + 1;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("sim failed");
		$finish;
	end

	task automatic check_outputs(input string tag);
		check_value({tag, " vram writes"}, vram_writes, exp_writes);
		check_value({tag, " frame_err pulses"}, err_pulses, exp_err_pulses);
		for (int a = 0; a < 256; a++)
			check_value($sformatf("%s vram[%0d]", tag, a), 32'(vram[a]), 32'(exp_vram[a]));
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d mismatches", name, error_count - errors_before);
		end
	endtask

	task automatic test_valid_msg();
		int errors_before;
		errors_before = error_count;
		// offset 3 lands on addresses 24 to 31
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_MSG, 8'd1, 8'd3, `FGP_LEN);
		send_frame(-1);
		expect_dgram();
		idle_cycles(IDLE_CYCLES);
		check_outputs("valid msg");
		report_test("valid msg", errors_before);
	endtask

	task automatic test_other_ethertype();
		int errors_before;
		errors_before = error_count;
		build_frame(16'h0800, `FFCP_TYPE_MSG, 8'd2, 8'd4, `FGP_LEN);
		send_frame(-1);
		idle_cycles(IDLE_CYCLES);
		check_outputs("other ethertype");
		report_test("other ethertype", errors_before);
	endtask

	task automatic test_non_msg();
		int errors_before;
		errors_before = error_count;
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_SYN, 8'd3, 8'd6, `FGP_LEN);
		send_frame(-1);
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_ACK, 8'd4, 8'd7, `FGP_LEN);
		send_frame(-1);
		// one datagram byte short
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_MSG, 8'd5, 8'd8, `FGP_LEN - 1);
		send_frame(-1);
		idle_cycles(IDLE_CYCLES);
		check_outputs("syn, ack and short msg");
		report_test("syn, ack and short msg", errors_before);
	endtask

	task automatic test_rx_error();
		int errors_before;
		errors_before = error_count;
		// rxerr inside the datagram, well past the ethertype
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_MSG, 8'd6, 8'd9, `FGP_LEN);
		send_frame(20);
		exp_err_pulses++;
		idle_cycles(IDLE_CYCLES);
		check_outputs("rx error frame");
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_MSG, 8'd7, 8'd9, `FGP_LEN);
		send_frame(-1);
		expect_dgram();
		idle_cycles(IDLE_CYCLES);
		check_outputs("frame after rx error");
		report_test("rx error", errors_before);
	endtask

	task automatic test_back_to_back();
		int errors_before;
		errors_before = error_count;
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_MSG, 8'd0, 8'd10, `FGP_LEN);
		send_frame(-1);
		expect_dgram();
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_MSG, 8'd1, 8'd11, `FGP_LEN);
		send_frame(-1);
		expect_dgram();
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_MSG, 8'd2, 8'd31, `FGP_LEN);
		send_frame(-1);
		expect_dgram();
		// same offset as the first frame, new colors win
		build_frame(`ETHERTYPE_FFCP, `FFCP_TYPE_MSG, 8'd3, 8'd10, `FGP_LEN);
		send_frame(-1);
		expect_dgram();
		idle_cycles(IDLE_CYCLES);
		check_outputs("back to back");
		report_test("back to back", errors_before);
	endtask

	initial begin
		rmii = '0;
		eth_rx_downstream_rst = 1'b1;
		lcg_state = 32'h6b1a_d465;
		exp_writes = 0;
		exp_err_pulses = 0;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int a = 0; a < 256; a++)
			exp_vram[a] = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		eth_rx_downstream_rst = 1'b0;

		test_valid_msg();
		test_other_ethertype();
		test_non_msg();
		test_rx_error();
		test_back_to_back();

		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
+incdir+testbench
common/eth_video_pkg.sv
source/rmii_rx.sv
frame/eth_frame_rx.sv
frame/ffcp_rx.sv
source/packet_buffer.sv
playback/slot_streamer.sv
playback/fgp_to_vram.sv
source/eth_video_rx.sv
testbench/tb_eth_video_rx.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP = tb_eth_video_rx
FILELIST = files.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
